//--- hw/break_vector.sv
/* Break vector and return address */
`timescale 1ns/10ps
`include "mb_pipe_settings.svh"

module break_vector
   import cpu_status_pkg::*;
   import pipe_pkg::*;
(
   input  logic    sys_clk_i,
   input  addr_t   pc_ex_i,
   pipe_ctl_if.dp  dp,
   output addr_t   vec_o,
   output addr_t   epc_o
);

   // Saved return address per thread
   addr_t epc_q [THR_N];
   logic  brk_take;

   // Handler entry, exception over interrupt
   always_comb begin
      if (dp.brk[BRK_EXC]) begin
         vec_o = `MB_VEC_EXC;
      end else if (dp.brk[BRK_INT]) begin
         vec_o = `MB_VEC_INT;
      end else begin
         vec_o = '0;
      end
   end

   // Same take condition as the MSR update
   assign brk_take = dp.dena & (dp.brk != '0);

   // PC in execute at the take edge is where the thread resumes
   always_ff @(posedge sys_clk_i) begin
      for (int t = 0; t < THR_N; t++) begin
         if (dp.grst) begin
            epc_q[t] <= '0;
         end else if (brk_take && (dp.brk_tid == tid_t'(t))) begin
            epc_q[t] <= pc_ex_i;
         end
      end
   end

   // Return address of the current phase
   assign epc_o = epc_q[dp.gpha];

endmodule

//--- hw/cpu_status_pkg.sv
/* Architectural status types */
package cpu_status_pkg;

   // Width of the machine status word
   localparam int MSR_W = 10;

   // Width of the exception cause field
   localparam int ESR_W = 2;

   // Instruction address width
   localparam int ADDR_W = 32;

   // Machine status register
   // IE, BIP, EE and EIP are the bits the core acts on
   typedef logic [MSR_W-1:0] msr_t;

   // Exception status register
   // Holds the cause code of the last taken exception
   typedef logic [ESR_W-1:0] esr_t;

   // Instruction address
   // Used for handler vectors and saved return addresses
   typedef logic [ADDR_W-1:0] addr_t;

endpackage

//--- hw/exc_status.sv
/* Per-thread exception cause */
`timescale 1ns/10ps
`include "mb_pipe_settings.svh"

module exc_status
   import cpu_status_pkg::*;
   import pipe_pkg::*;
(
   input  logic       sys_clk_i,
   input  logic       exc_ill_i,
   input  logic [1:0] exc_dwb_i,
   input  logic       exc_iwb_i,
   pipe_ctl_if.dp     dp,
   output esr_t       esr_o
);

   esr_t cause_d;
   esr_t cause_q;
   esr_t esr_q [THR_N];

   // Illegal first, then data bus, then instruction bus
   always_comb begin
      if (exc_ill_i) begin
         cause_d = `MB_CAUSE_ILL;
      end else if (exc_dwb_i[1]) begin
         cause_d = `MB_CAUSE_DBUS;
      end else if (exc_iwb_i) begin
         cause_d = `MB_CAUSE_IBUS;
      end else begin
         cause_d = `MB_CAUSE_NONE;
      end
   end

   // Cause travels alongside the break request
   always_ff @(posedge sys_clk_i) begin
      if (dp.dena) begin
         cause_q <= cause_d;
      end
   end

   // Commit into the ESR of the breaking thread
   always_ff @(posedge sys_clk_i) begin
      for (int t = 0; t < THR_N; t++) begin
         if (dp.grst) begin
            esr_q[t] <= '0;
         end else if (dp.dena && dp.brk[BRK_EXC] && (dp.brk_tid == tid_t'(t))) begin
            esr_q[t] <= cause_q;
         end
      end
   end

   assign esr_o = esr_q[dp.gpha];

endmodule

//--- hw/mb_pipe_settings.svh
/* Pipeline control settings */
`ifndef MB_PIPE_SETTINGS_SVH
`define MB_PIPE_SETTINGS_SVH

// Edges from reset release to internal reset drop
`define MB_RST_DELAY 2

// Handler entry addresses
`define MB_VEC_INT 32'h10
`define MB_VEC_EXC 32'h20

// Exception cause codes held in the ESR
`define MB_CAUSE_NONE 2'd0
`define MB_CAUSE_ILL  2'd1
`define MB_CAUSE_DBUS 2'd2
`define MB_CAUSE_IBUS 2'd3

// MSR bit positions
`define MB_MSR_IE  1
`define MB_MSR_BIP 3
`define MB_MSR_EE  8
`define MB_MSR_EIP 9

`endif

//--- hw/mb_pipe_top.sv
/* Pipeline control top level */
`timescale 1ns/10ps

module mb_pipe_top
   import cpu_status_pkg::*;
   import pipe_pkg::*;
(
   input  logic       sys_clk_i,
   input  logic       sys_rst_i,
   input  logic       sys_ena_i,
   input  logic       sys_int_i,
   input  logic       ich_fb_i,
   input  logic       xwb_fb_i,
   input  logic       dwb_fb_i,
   input  logic       exc_ill_i,
   input  logic [1:0] exc_dwb_i,
   input  logic       exc_iwb_i,
   input  logic       msr_we_i,
   input  msr_t       msr_wdata_i,
   input  logic       rtid_i,
   input  logic       rtie_i,
   input  addr_t      pc_ex_i,
   output logic       grst_o,
   output tid_t       gpha_o,
   output logic       dena_o,
   output brk_t       brk_o,
   output addr_t      vec_o,
   output msr_t       msr_o,
   output esr_t       esr_o,
   output addr_t      epc_o
);

   // Control bundle to the datapath side
   pipe_ctl_if ctl_if ();

   // MSR of the current phase, fed back to control
   msr_t msr_cur;

   pipe_ctl u_pipe_ctl (
      .sys_clk_i (sys_clk_i),
      .sys_rst_i (sys_rst_i),
      .sys_ena_i (sys_ena_i),
      .sys_int_i (sys_int_i),
      .ich_fb_i  (ich_fb_i),
      .xwb_fb_i  (xwb_fb_i),
      .dwb_fb_i  (dwb_fb_i),
      .exc_ill_i (exc_ill_i),
      .exc_dwb_i (exc_dwb_i),
      .exc_iwb_i (exc_iwb_i),
      .msr_cur_i (msr_cur),
      .ctl       (ctl_if.ctl)
   );

   msr_unit u_msr_unit (
      .sys_clk_i   (sys_clk_i),
      .msr_we_i    (msr_we_i),
      .msr_wdata_i (msr_wdata_i),
      .rtid_i      (rtid_i),
      .rtie_i      (rtie_i),
      .dp          (ctl_if.dp),
      .msr_cur_o   (msr_cur)
   );

   exc_status u_exc_status (
      .sys_clk_i (sys_clk_i),
      .exc_ill_i (exc_ill_i),
      .exc_dwb_i (exc_dwb_i),
      .exc_iwb_i (exc_iwb_i),
      .dp        (ctl_if.dp),
      .esr_o     (esr_o)
   );

   break_vector u_break_vector (
      .sys_clk_i (sys_clk_i),
      .pc_ex_i   (pc_ex_i),
      .dp        (ctl_if.dp),
      .vec_o     (vec_o),
      .epc_o     (epc_o)
   );

   // Control levels out to the pins
   assign grst_o = ctl_if.grst;
   assign gpha_o = ctl_if.gpha;
   assign dena_o = ctl_if.dena;
   assign brk_o  = ctl_if.brk;
   assign msr_o  = msr_cur;

endmodule

//--- hw/msr_unit.sv
/* Per-thread MSR */
`timescale 1ns/10ps
`include "mb_pipe_settings.svh"

module msr_unit
   import cpu_status_pkg::*;
   import pipe_pkg::*;
(
   input  logic    sys_clk_i,
   input  logic    msr_we_i,
   input  msr_t    msr_wdata_i,
   input  logic    rtid_i,
   input  logic    rtie_i,
   pipe_ctl_if.dp  dp,
   output msr_t    msr_cur_o
);

   // One status word per thread
   msr_t msr_q [THR_N];
   msr_t msr_nxt [THR_N];
   logic brk_take;

   // Break is taken on an enabled edge only
   assign brk_take = dp.dena & (dp.brk != '0);

   always_comb begin
      for (int t = 0; t < THR_N; t++) begin
         msr_nxt[t] = msr_q[t];
         if (brk_take && (dp.brk_tid == tid_t'(t))) begin
            // Exception entry
            if (dp.brk[BRK_EXC]) begin
               msr_nxt[t][`MB_MSR_EIP] = 1'b1;
            end
            // Interrupt entry masks further interrupts
            if (dp.brk[BRK_INT]) begin
               msr_nxt[t][`MB_MSR_IE]  = 1'b0;
               msr_nxt[t][`MB_MSR_BIP] = 1'b1;
            end
         end else if (dp.gpha == tid_t'(t)) begin
            if (rtie_i || rtid_i) begin
               // Return from exception
               if (rtie_i) begin
                  msr_nxt[t][`MB_MSR_EIP] = 1'b0;
               end
               // Return from interrupt
               if (rtid_i) begin
                  msr_nxt[t][`MB_MSR_IE]  = 1'b1;
                  msr_nxt[t][`MB_MSR_BIP] = 1'b0;
               end
            end else if (msr_we_i) begin
               // Software write, lowest priority
               msr_nxt[t] = msr_wdata_i;
            end
         end
      end
   end

   always_ff @(posedge sys_clk_i) begin
      for (int t = 0; t < THR_N; t++) begin
         if (dp.grst) begin
            msr_q[t] <= '0;
         end else begin
            msr_q[t] <= msr_nxt[t];
         end
      end
   end

   // Status of the thread in the current phase
   assign msr_cur_o = msr_q[dp.gpha];

endmodule

//--- hw/pipe_ctl.sv
/* Pipeline and system control */
`timescale 1ns/10ps
`include "mb_pipe_settings.svh"

module pipe_ctl
   import cpu_status_pkg::*;
   import pipe_pkg::*;
(
   input  logic       sys_clk_i,
   input  logic       sys_rst_i,
   input  logic       sys_ena_i,
   input  logic       sys_int_i,
   input  logic       ich_fb_i,
   input  logic       xwb_fb_i,
   input  logic       dwb_fb_i,
   input  logic       exc_ill_i,
   input  logic [1:0] exc_dwb_i,
   input  logic       exc_iwb_i,
   input  msr_t       msr_cur_i,
   pipe_ctl_if.ctl    ctl
);

   // Reset release shifter
   logic [`MB_RST_DELAY-1:0] rst_sr;
   logic                     grst;
   logic                     dena;
   tid_t                     gpha_q;
   logic                     int_lat;
   logic                     exc;
   brk_t                     brk_d;
   brk_t                     brk_q;
   tid_t                     brk_tid_q;

   // Ones shift in after the external reset drops
   always_ff @(posedge sys_clk_i) begin
      if (sys_rst_i) begin
         rst_sr <= '0;
      end else begin
         rst_sr <= {rst_sr[`MB_RST_DELAY-2:0], 1'b1};
      end
   end

   // High during external reset and until the shifter fills
   assign grst = sys_rst_i | ~rst_sr[`MB_RST_DELAY-1];

   // All buses ready and the system enabled
   assign dena = ich_fb_i & xwb_fb_i & dwb_fb_i & sys_ena_i;

   // Phase toggle, also runs while grst is held
   always_ff @(posedge sys_clk_i) begin
      if (sys_rst_i) begin
         gpha_q <= 1'b0;
      end else if (dena | grst) begin
         gpha_q <= ~gpha_q;
      end
   end

   // Interrupt latch, held until IE drops in the current thread
   always_ff @(posedge sys_clk_i) begin
      if (sys_rst_i) begin
         int_lat <= 1'b0;
      end else begin
         int_lat <= msr_cur_i[`MB_MSR_IE] & (int_lat | sys_int_i);
      end
   end

   // Any exception source, instruction bus errors included
   assign exc = exc_ill_i | exc_dwb_i[1] | exc_iwb_i;

   // Exception wins over interrupt, EIP blocks both
   always_comb begin
      brk_d          = '0;
      brk_d[BRK_EXC] = exc & msr_cur_i[`MB_MSR_EE] & ~msr_cur_i[`MB_MSR_EIP];
      brk_d[BRK_INT] = ~exc & ~msr_cur_i[`MB_MSR_EIP] & ~msr_cur_i[`MB_MSR_BIP] & int_lat;
   end

   // Break request with its thread tag
   always_ff @(posedge sys_clk_i) begin
      if (grst) begin
         brk_q     <= '0;
         brk_tid_q <= 1'b0;
      end else if (dena) begin
         brk_q     <= brk_d;
         brk_tid_q <= gpha_q;
      end
   end

   assign ctl.grst    = grst;
   assign ctl.gpha    = gpha_q;
   assign ctl.dena    = dena;
   assign ctl.brk     = brk_q;
   assign ctl.brk_tid = brk_tid_q;

endmodule

//--- hw/pipe_ctl_if.sv
/* Pipeline control bundle */
`timescale 1ns/10ps

interface pipe_ctl_if
   import pipe_pkg::*;
();

   // Internal reset, held past the external release
   logic grst;
   // Current thread
   tid_t gpha;
   // Pipeline enable from the bus ready levels
   logic dena;
   // Registered break request
   brk_t brk;
   // Thread the pending break belongs to
   tid_t brk_tid;

   // Driven by the control block
   modport ctl (
      output grst,
      output gpha,
      output dena,
      output brk,
      output brk_tid
   );

   // Seen by the datapath blocks
   modport dp (
      input grst,
      input gpha,
      input dena,
      input brk,
      input brk_tid
   );

endinterface

//--- hw/pipe_pkg.sv
/* Pipeline control types */
package pipe_pkg;

   // Two hardware threads, interleaved by phase
   localparam int THR_N = 2;

   // Bit positions inside a break request
   localparam int BRK_EXC = 1;
   localparam int BRK_INT = 0;

   // Break request
   // Exception in the upper bit, interrupt in the lower
   typedef logic [1:0] brk_t;

   // Thread id, same value as the phase
   typedef logic tid_t;

endpackage

//--- mb_pipe.f
+incdir+hw
hw/cpu_status_pkg.sv
hw/pipe_pkg.sv
hw/pipe_ctl_if.sv
hw/pipe_ctl.sv
hw/msr_unit.sv
hw/exc_status.sv
hw/break_vector.sv
hw/mb_pipe_top.sv
test/mb_pipe_tb.sv

//--- test/mb_pipe_tb.sv
/* Pipeline control testbench */
`timescale 1ns/10ps
`include "mb_pipe_settings.svh"

module mb_pipe_tb
   import cpu_status_pkg::*;
   import pipe_pkg::*;
;

   // Test lengths in cycles, the run limit follows from them
   localparam int RST_LEN   = 20;
   localparam int STALL_LEN = 24;
   localparam int INT_LEN   = 20;
   localparam int EXC_LEN   = 60;
   localparam int ISO_LEN   = 25;
   localparam int LIMIT     = RST_LEN + STALL_LEN + INT_LEN + EXC_LEN + ISO_LEN + 100;

   localparam msr_t IE  = msr_t'(1) << `MB_MSR_IE;
   localparam msr_t BIP = msr_t'(1) << `MB_MSR_BIP;
   localparam msr_t EE  = msr_t'(1) << `MB_MSR_EE;
   localparam msr_t EIP = msr_t'(1) << `MB_MSR_EIP;

   logic       sys_clk_i;
   logic       sys_rst_i;
   logic       sys_ena_i;
   logic       sys_int_i;
   logic       ich_fb_i;
   logic       xwb_fb_i;
   logic       dwb_fb_i;
   logic       exc_ill_i;
   logic [1:0] exc_dwb_i;
   logic       exc_iwb_i;
   logic       msr_we_i;
   msr_t       msr_wdata_i;
   logic       rtid_i;
   logic       rtie_i;
   addr_t      pc_ex_i;
   logic       grst_o;
   tid_t       gpha_o;
   logic       dena_o;
   brk_t       brk_o;
   addr_t      vec_o;
   msr_t       msr_o;
   esr_t       esr_o;
   addr_t      epc_o;

   int          errors = 0;
   int          checks = 0;
   int          cycles = 0;
   logic [31:0] rng    = 32'hd2b0;

   // Reference state, one entry per thread where the core keeps one
   logic [1:0] m_rel  = '0;
   tid_t       m_pha  = 1'b0;
   logic       m_lat  = 1'b0;
   brk_t       m_brk  = '0;
   tid_t       m_btid = 1'b0;
   esr_t       m_cause = '0;
   msr_t       m_msr [2] = '{default: '0};
   esr_t       m_esr [2] = '{default: '0};
   addr_t      m_epc [2] = '{default: '0};

   mb_pipe_top uut (.*);

   initial begin
      sys_clk_i = 1'b0;
      forever #2 sys_clk_i = ~sys_clk_i;
   end

   // Run limit
   always @(posedge sys_clk_i) begin
      cycles++;
      if (cycles > LIMIT) begin
         $display("Timeout: no result after %0d cycles", LIMIT);
         $display("Simulation failed");
         $finish;
      end
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("** Error %s: got %h, expected %h at %0t", name, got, exp, $time);
      end
   endtask

   // One clock edge, the model steps along with the DUT
   task automatic advance();
      logic ena;
      logic grst;
      logic exc;
      logic take;
      msr_t cur;
      msr_t nmsr [2];
      int   t;
      #1;
      ena  = ich_fb_i & xwb_fb_i & dwb_fb_i & sys_ena_i;
      grst = sys_rst_i | (m_rel < 2);
      exc  = exc_ill_i | exc_dwb_i[1] | exc_iwb_i;
      take = ena & (m_brk != 2'b00);
      cur  = m_msr[m_pha];
      expect_eq("grst_o", grst_o, grst);
      expect_eq("dena_o", dena_o, ena);
      for (t = 0; t < 2; t++) begin
         nmsr[t] = m_msr[t];
         if (grst) begin
            nmsr[t]  = '0;
            m_esr[t] = '0;
            m_epc[t] = '0;
         end else begin
            // Break first, then returns, then software write
            if (take && m_btid == t) begin
               if (m_brk[1]) nmsr[t] = nmsr[t] | EIP;
               if (m_brk[0]) nmsr[t] = (nmsr[t] & ~IE) | BIP;
               m_epc[t] = pc_ex_i;
            end else if (m_pha == t && (rtie_i || rtid_i)) begin
               if (rtie_i) nmsr[t] = nmsr[t] & ~EIP;
               if (rtid_i) nmsr[t] = (nmsr[t] | IE) & ~BIP;
            end else if (m_pha == t && msr_we_i) begin
               nmsr[t] = msr_wdata_i;
            end
            if (ena && m_brk[1] && m_btid == t) m_esr[t] = m_cause;
         end
      end
      m_msr = nmsr;
      if (ena) begin
         m_cause = exc_ill_i ? `MB_CAUSE_ILL : exc_dwb_i[1] ? `MB_CAUSE_DBUS :
                   exc_iwb_i ? `MB_CAUSE_IBUS : `MB_CAUSE_NONE;
      end
      // Exception masks interrupt, EIP blocks both
      if (grst) begin
         m_brk  = '0;
         m_btid = 1'b0;
      end else if (ena) begin
         m_brk[1] = exc & cur[`MB_MSR_EE] & ~cur[`MB_MSR_EIP];
         m_brk[0] = ~exc & ~cur[`MB_MSR_EIP] & ~cur[`MB_MSR_BIP] & m_lat;
         m_btid   = m_pha;
      end
      m_lat = sys_rst_i ? 1'b0 : cur[`MB_MSR_IE] & (m_lat | sys_int_i);
      m_pha = sys_rst_i ? 1'b0 : (ena | grst) ? ~m_pha : m_pha;
      m_rel = sys_rst_i ? 2'd0 : (m_rel < 2) ? m_rel + 2'd1 : m_rel;
      @(negedge sys_clk_i);
      expect_eq("gpha_o", gpha_o, m_pha);
      expect_eq("brk_o", brk_o, m_brk);
      expect_eq("vec_o", vec_o, m_brk[1] ? `MB_VEC_EXC : m_brk[0] ? `MB_VEC_INT : 32'h0);
      expect_eq("msr_o", msr_o, m_msr[m_pha]);
      expect_eq("esr_o", esr_o, m_esr[m_pha]);
      expect_eq("epc_o", epc_o, m_epc[m_pha]);
      rng = xorshift(rng);
      pc_ex_i = rng;
   endtask

   // Software MSR write in the phase of thread t
   task automatic write_msr(input tid_t t, input msr_t val);
      while (gpha_o != t) advance();
      msr_we_i    = 1'b1;
      msr_wdata_i = val;
      advance();
      msr_we_i = 1'b0;
   endtask

   task automatic reset_release();
      repeat (15) begin
         advance();
         expect_eq("grst_o", grst_o, 1'b1);
      end
      sys_rst_i = 1'b0;
      advance();
      expect_eq("grst_o", grst_o, 1'b1);
      advance();
      expect_eq("grst_o", grst_o, 1'b0);
      expect_eq("dena_o", dena_o, 1'b0);
      expect_eq("gpha_o", gpha_o, 1'b0);
      expect_eq("brk_o", brk_o, 2'b00);
      expect_eq("vec_o", vec_o, 32'h0);
      expect_eq("msr_o", msr_o, 10'h0);
      expect_eq("esr_o", esr_o, 2'd0);
      expect_eq("epc_o", epc_o, 32'h0);
   endtask

   task automatic phase_stall();
      // Each ready level is low about one cycle in four
      repeat (STALL_LEN) begin
         rng       = xorshift(rng);
         ich_fb_i  = |rng[1:0];
         xwb_fb_i  = |rng[3:2];
         dwb_fb_i  = |rng[5:4];
         sys_ena_i = |rng[7:6];
         advance();
      end
      ich_fb_i  = 1'b1;
      xwb_fb_i  = 1'b1;
      dwb_fb_i  = 1'b1;
      sys_ena_i = 1'b1;
   endtask

   task automatic interrupt_entry();
      addr_t pc_take;
      write_msr(1'b0, IE | EE);
      write_msr(1'b1, IE | EE);
      while (gpha_o != 1'b0) advance();
      sys_int_i = 1'b1;
      advance();
      sys_int_i = 1'b0;
      // Latched request turns into a break tagged to thread 1
      advance();
      expect_eq("brk_o", brk_o, 2'b01);
      expect_eq("vec_o", vec_o, `MB_VEC_INT);
      pc_take = pc_ex_i;
      advance();
      expect_eq("msr_o[IE]", msr_o[`MB_MSR_IE], 1'b0);
      expect_eq("msr_o[BIP]", msr_o[`MB_MSR_BIP], 1'b1);
      expect_eq("epc_o", epc_o, pc_take);
      // IE clear in both threads, BIP clear too
      write_msr(1'b0, EE);
      write_msr(1'b1, EE);
      sys_int_i = 1'b1;
      advance();
      sys_int_i = 1'b0;
      repeat (3) begin
         advance();
         expect_eq("brk_o", brk_o, 2'b00);
      end
   endtask

   task automatic bus_exception(input logic [1:0] dwb, input logic iwb, input esr_t code);
      repeat (4) advance();
      write_msr(1'b0, EE);
      write_msr(1'b1, EE);
      exc_dwb_i = dwb;
      exc_iwb_i = iwb;
      advance();
      exc_dwb_i = 2'b00;
      exc_iwb_i = 1'b0;
      expect_eq("brk_o", brk_o, 2'b10);
      advance();
      expect_eq("esr_o", esr_o, code);
   endtask

   task automatic exception_priority();
      write_msr(1'b0, IE | EE);
      write_msr(1'b1, IE | EE);
      sys_int_i = 1'b1;
      advance();
      sys_int_i = 1'b0;
      // Illegal opcode arrives with the interrupt already latched
      exc_ill_i = 1'b1;
      advance();
      exc_ill_i = 1'b0;
      expect_eq("brk_o", brk_o, 2'b10);
      expect_eq("vec_o", vec_o, `MB_VEC_EXC);
      advance();
      expect_eq("esr_o", esr_o, `MB_CAUSE_ILL);
      bus_exception(2'b10, 1'b0, `MB_CAUSE_DBUS);
      bus_exception(2'b00, 1'b1, `MB_CAUSE_IBUS);
      // Handler already running
      repeat (4) advance();
      write_msr(1'b0, EE | EIP);
      write_msr(1'b1, EE | EIP);
      exc_ill_i = 1'b1;
      advance();
      exc_ill_i = 1'b0;
      expect_eq("brk_o", brk_o, 2'b00);
      advance();
      expect_eq("brk_o", brk_o, 2'b00);
   endtask

   task automatic thread_isolation();
      msr_t  keep_msr;
      esr_t  keep_esr;
      addr_t keep_epc;
      repeat (4) advance();
      write_msr(1'b0, EE);
      write_msr(1'b1, EE | EIP);
      advance();
      keep_msr = msr_o;
      keep_esr = esr_o;
      keep_epc = epc_o;
      advance();
      // Break on thread 0, thread 1 is watched in between
      exc_dwb_i = 2'b10;
      advance();
      exc_dwb_i = 2'b00;
      expect_eq("msr_o", msr_o, keep_msr);
      advance();
      expect_eq("esr_o", esr_o, `MB_CAUSE_DBUS);
      expect_eq("msr_o[EIP]", msr_o[`MB_MSR_EIP], 1'b1);
      advance();
      expect_eq("msr_o", msr_o, keep_msr);
      expect_eq("esr_o", esr_o, keep_esr);
      expect_eq("epc_o", epc_o, keep_epc);
      // Return from exception in thread 0 only
      advance();
      rtie_i = 1'b1;
      advance();
      rtie_i = 1'b0;
      expect_eq("msr_o[EIP]", msr_o[`MB_MSR_EIP], 1'b1);
      advance();
      expect_eq("msr_o[EIP]", msr_o[`MB_MSR_EIP], 1'b0);
      // Return from interrupt in thread 1 only
      advance();
      rtid_i = 1'b1;
      advance();
      rtid_i = 1'b0;
      expect_eq("msr_o[IE]", msr_o[`MB_MSR_IE], 1'b0);
      advance();
      expect_eq("msr_o[IE]", msr_o[`MB_MSR_IE], 1'b1);
   endtask

   initial begin
      sys_rst_i   = 1'b1;
      sys_ena_i   = 1'b0;
      sys_int_i   = 1'b0;
      ich_fb_i    = 1'b1;
      xwb_fb_i    = 1'b1;
      dwb_fb_i    = 1'b1;
      exc_ill_i   = 1'b0;
      exc_dwb_i   = 2'b00;
      exc_iwb_i   = 1'b0;
      msr_we_i    = 1'b0;
      msr_wdata_i = '0;
      rtid_i      = 1'b0;
      rtie_i      = 1'b0;
      pc_ex_i     = '0;
      @(negedge sys_clk_i);
      reset_release();
      phase_stall();
      interrupt_entry();
      exception_priority();
      thread_isolation();
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule
